//--- flist.f
+incdir+verification
logic/commit_pkg.sv
logic/csr_pkg.sv
logic/commit_slot_check.sv
logic/commit_select.sv
logic/csr_file.sv
logic/commit_stage.sv
verification/commit_stage_tb.sv

//--- Bender.yml
package:
  name: commit_stage

sources:
  - logic/commit_pkg.sv
  - logic/csr_pkg.sv
  - logic/commit_slot_check.sv
  - logic/commit_select.sv
  - logic/csr_file.sv
  - logic/commit_stage.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/commit_stage_tb.sv

//--- verification/commit_tests.svh
`ifndef COMMIT_TESTS_SVH
`define COMMIT_TESTS_SVH

// ----------------------------------------
// entry builders and drive helpers

function automatic rob_entry_t plain_entry(input logic [31:0] pc,
                                           input logic [AREG_W-1:0] areg,
                                           input logic [31:0] data);
    rob_entry_t e;
    e        = '0;
    e.pc     = pc;
    e.w_reg  = 1'b1;
    e.w_areg = areg;
    e.w_data = data;
    return e;
endfunction

function automatic rob_entry_t csr_entry(input csr_op_e op, input logic [13:0] num,
                                         input logic [31:0] wdata, input logic [31:0] mask);
    rob_entry_t e;
    e           = plain_entry(CSR_PC, 5'd4, 32'h0);
    e.csr_op    = op;
    e.csr_num   = num;
    e.csr_wdata = wdata;
    e.csr_mask  = mask;
    return e;
endfunction

// one cycle of ROB head with outputs sampled 1 ns before the next edge
task automatic present(input logic [1:0] valid, input rob_entry_t e0, input rob_entry_t e1);
    @(posedge clk);
    #1;
    rob_valid    = valid;
    rob_entry[0] = e0;
    rob_entry[1] = e1;
    #(CLK_PERIOD - 2);
endtask

task automatic read_csr(input logic [13:0] num, output logic [31:0] value);
    present(2'b01, csr_entry(CSR_OP_READ, num, 32'h0, 32'h0), '0);
    compare(commit_request, 2'b01, "csr read retires");
    compare(arf_we, 2'b01, "csr read writes rd");
    compare(flush, 1'b0, "csr read does not flush");
    value = arf_data[0];
endtask

task automatic update_csr(input csr_op_e op, input logic [13:0] num,
                          input logic [31:0] wdata, input logic [31:0] mask);
    present(2'b01, csr_entry(op, num, wdata, mask), '0);
    compare(flush, 1'b1, "csr update flushes");
    compare(flush_pc, CSR_PC + 32'd4, "csr update flush target");
endtask

// ----------------------------------------
// directed tests

task automatic dual_retire();
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] d0;
    logic [31:0] d1;
    take_bits(AREG_W, a0);
    take_bits(AREG_W, a1);
    take_bits(32, d0);
    take_bits(32, d1);
    present(2'b11, plain_entry(32'h1c00_0000, a0[AREG_W-1:0], d0),
            plain_entry(32'h1c00_0004, a1[AREG_W-1:0], d1));
    compare(commit_request, 2'b11, "dual request");
    compare(arf_we, 2'b11, "dual arf write");
    compare(arf_areg[0], a0, "slot 0 areg");
    compare(arf_areg[1], a1, "slot 1 areg");
    compare(arf_data[0], d0, "slot 0 data");
    compare(arf_data[1], d1, "slot 1 data");
    compare(flush, 1'b0, "dual retire flush");
    // slot 1 present but not valid
    present(2'b01, plain_entry(32'h1c00_0008, a1[AREG_W-1:0], d1),
            plain_entry(32'h1c00_000c, a0[AREG_W-1:0], d0));
    compare(commit_request, 2'b01, "single request");
    compare(arf_we, 2'b01, "single arf write");
endtask

task automatic solo_rule();
    rob_entry_t e0;
    rob_entry_t e1;
    for (int c = 0; c < 3; c++) begin
        e0 = plain_entry(32'h1c00_0100, 5'd1, 32'h1111_0000 + c);
        e1 = plain_entry(32'h1c00_0104, 5'd2, 32'h2222_0000 + c);
        case (c)
            0: e1.solo = 1'b1;
            1: e1.csr_op = CSR_OP_READ;
            default: e0.solo = 1'b1;
        endcase
        present(2'b11, e0, e1);
        compare(commit_request, 2'b01, $sformatf("solo case %0d request", c));
        compare(arf_we, 2'b01, $sformatf("solo case %0d arf write", c));
    end
endtask

task automatic csr_access();
    logic [31:0] value;
    update_csr(CSR_OP_WRITE, CSR_EENTRY, 32'h1c00_0abc, 32'h0);
    read_csr(CSR_EENTRY, value);
    compare(value, 32'h1c00_0a80, "EENTRY low bits cleared");
    update_csr(CSR_OP_WRITE, CSR_ECFG, 32'h0000_0f0f, 32'h0);
    // only mask bits inside LIE change
    update_csr(CSR_OP_XCHG, CSR_ECFG, 32'h0000_3000, 32'h0000_f00f);
    compare(arf_data[0], 32'h0000_0f0f, "exchange returns old ECFG");
    read_csr(CSR_ECFG, value);
    compare(value, 32'h0000_1f00, "ECFG after exchange");
    update_csr(CSR_OP_WRITE, CSR_ECFG, 32'h0, 32'h0);
endtask

task automatic exception_entry();
    rob_entry_t  e;
    logic [31:0] value;
    update_csr(CSR_OP_WRITE, CSR_EENTRY, EXC_BASE, 32'h0);
    // kernel mode 1 with interrupts on
    update_csr(CSR_OP_WRITE, CSR_CRMD, 32'h0000_000d, 32'h0);

    e         = plain_entry(32'h1c00_0400, 5'd7, 32'h5555_aaaa);
    e.syscall = 1'b1;
    e.brk     = 1'b1;
    present(2'b11, e, plain_entry(32'h1c00_0404, 5'd8, 32'h0));
    compare(commit_request, 2'b01, "trap retires alone");
    compare(arf_we, 2'b00, "trap writes no register");
    compare(flush, 1'b1, "trap flush");
    compare(flush_pc, EXC_BASE, "trap flush target");

    read_csr(CSR_ESTAT, value);
    compare(value[21:16], ECODE_SYS, "syscall wins over break");
    read_csr(CSR_ERA, value);
    compare(value, 32'h1c00_0400, "ERA holds trap pc");
    read_csr(CSR_PRMD, value);
    compare(value, 32'h0000_0005, "PRMD saved PLV and IE");
    read_csr(CSR_CRMD, value);
    compare(value, 32'h0000_0008, "CRMD back to kernel");

    e           = plain_entry(32'h1c00_0500, 5'd9, 32'h0);
    e.fetch_exc = 1'b1;
    e.exc_code  = 6'h03;
    e.va        = 32'h0bad_f00d;
    present(2'b01, e, '0);
    compare(flush, 1'b1, "fetch fault flush");
    read_csr(CSR_ESTAT, value);
    compare(value[21:16], 6'h03, "fetch fault code");
    read_csr(CSR_BADV, value);
    compare(value, 32'h0bad_f00d, "BADV from fetch fault");
endtask

task automatic interrupt_and_priv();
    rob_entry_t  e;
    logic [31:0] value;
    // hw line 0 lands on IS bit 2
    update_csr(CSR_OP_WRITE, CSR_ECFG, 32'h0000_0004, 32'h0);
    update_csr(CSR_OP_WRITE, CSR_CRMD, 32'h0000_000c, 32'h0);
    @(posedge clk);
    #1;
    rob_valid = '0;
    hw_int    = 8'h01;
    present(2'b01, plain_entry(32'h1c00_0600, 5'd3, 32'h1234_5678), '0);
    compare(flush, 1'b1, "interrupt flush");
    compare(flush_pc, EXC_BASE, "interrupt flush target");
    compare(arf_we, 2'b00, "interrupted entry writes nothing");
    @(posedge clk);
    #1;
    rob_valid = '0;
    hw_int    = 8'h00;
    read_csr(CSR_ESTAT, value);
    compare(value[21:16], ECODE_INT, "interrupt code");

    e      = plain_entry(32'h1c00_0700, 5'd5, 32'h0);
    e.priv = 1'b1;
    present(2'b01, e, '0);
    compare(flush, 1'b0, "privileged op allowed in kernel");
    update_csr(CSR_OP_WRITE, CSR_CRMD, 32'h0000_000b, 32'h0);
    present(2'b01, e, '0);
    compare(flush, 1'b1, "privileged op traps in user mode");
    compare(arf_we, 2'b00, "privilege fault writes nothing");
    read_csr(CSR_ESTAT, value);
    compare(value[21:16], ECODE_IPE, "privilege fault code");
endtask

`endif

//--- verification/commit_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module commit_stage_tb;

    import commit_pkg::*;
    import csr_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          MAX_CYCLES = 1000;
    localparam logic [31:0] LFSR_SEED  = 32'h3e4a_19d9;
    // pc of every CSR instruction entry
    localparam logic [31:0] CSR_PC     = 32'h1c00_0200;
    localparam logic [31:0] EXC_BASE   = 32'h1c00_8000;

    logic                                   clk;
    logic                                   rst_n;
    logic [COMMIT_WIDTH-1:0]                rob_valid;
    rob_entry_t [COMMIT_WIDTH-1:0]          rob_entry;
    logic [7:0]                             hw_int;
    logic [COMMIT_WIDTH-1:0]                commit_request;
    logic [COMMIT_WIDTH-1:0]                arf_we;
    logic [COMMIT_WIDTH-1:0][AREG_W-1:0]    arf_areg;
    logic [COMMIT_WIDTH-1:0][31:0]          arf_data;
    logic                                   flush;
    logic [31:0]                            flush_pc;
    logic [31:0]                            lfsr;
    int                                     cycle_count = 0;

    commit_stage dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .rob_valid_i      (rob_valid),
        .rob_entry_i      (rob_entry),
        .hw_int_i         (hw_int),
        .commit_request_o (commit_request),
        .arf_we_o         (arf_we),
        .arf_areg_o       (arf_areg),
        .arf_data_o       (arf_data),
        .flush_o          (flush),
        .flush_pc_o       (flush_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[31]};
        end
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
        if (actual !== expected) begin
            $display("ERR @ %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

`include "commit_tests.svh"

    // ----------------------------------------
    // test sequence
    initial begin
        logic [31:0] value;
        clk       = 1'b0;
        rst_n     = 1'b0;
        rob_valid = '0;
        rob_entry = '0;
        hw_int    = '0;
        lfsr      = LFSR_SEED;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle outputs and reset value of CRMD
        present(2'b00, '0, '0);
        compare(commit_request, 2'b00, "idle commit request");
        compare(arf_we, 2'b00, "idle arf write");
        compare(flush, 1'b0, "idle flush");
        read_csr(CSR_CRMD, value);
        compare(value, 32'h0000_0008, "CRMD after reset");

        dual_retire();
        solo_rule();
        csr_access();
        exception_entry();
        interrupt_and_priv();

        @(posedge clk);
        #1;
        rob_valid = '0;
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [commit_pkg::COMMIT_WIDTH-1:0]                        rob_valid_i,
    input  commit_pkg::rob_entry_t [commit_pkg::COMMIT_WIDTH-1:0]      rob_entry_i,
    input  logic [7:0]                                                 hw_int_i,
    output logic [commit_pkg::COMMIT_WIDTH-1:0]                        commit_request_o,
    output logic [commit_pkg::COMMIT_WIDTH-1:0]                        arf_we_o,
    output logic [commit_pkg::COMMIT_WIDTH-1:0][commit_pkg::AREG_W-1:0] arf_areg_o,
    output logic [commit_pkg::COMMIT_WIDTH-1:0][31:0]                  arf_data_o,
    output logic                                                       flush_o,
    output logic [31:0]                                                flush_pc_o
);

    import commit_pkg::*;
    import csr_pkg::*;

    csr_view_t                        csr_view;
    slot_result_t [COMMIT_WIDTH-1:0]  slot_result;
    csr_req_t                         csr_req;
    exc_req_t                         exc_req;
    logic [31:0]                      csr_rdata;
    logic [31:0]                      eentry;

    // ----------------------------------------
    // control registers
    csr_file u_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .hw_int_i    (hw_int_i),
        .csr_req_i   (csr_req),
        .exc_req_i   (exc_req),
        .csr_rdata_o (csr_rdata),
        .eentry_o    (eentry),
        .csr_view_o  (csr_view)
    );

    // one checker per retire slot
    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : g_slot
        commit_slot_check u_slot_check (
            .rob_entry_i  (rob_entry_i[i]),
            .csr_view_i   (csr_view),
            .slot_valid_i (rob_valid_i[i]),
            .result_o     (slot_result[i])
        );
    end

    // ----------------------------------------
    // retire decision and side effects
    commit_select u_commit_select (
        .rob_valid_i      (rob_valid_i),
        .rob_entry_i      (rob_entry_i),
        .result_i         (slot_result),
        .csr_rdata_i      (csr_rdata),
        .eentry_i         (eentry),
        .commit_request_o (commit_request_o),
        .arf_we_o         (arf_we_o),
        .arf_areg_o       (arf_areg_o),
        .arf_data_o       (arf_data_o),
        .flush_o          (flush_o),
        .flush_pc_o       (flush_pc_o),
        .csr_req_o        (csr_req),
        .exc_req_o        (exc_req)
    );

endmodule

`default_nettype wire

//--- logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         hw_int_i,
    input  csr_pkg::csr_req_t  csr_req_i,
    input  csr_pkg::exc_req_t  exc_req_i,
    output logic [31:0]        csr_rdata_o,
    output logic [31:0]        eentry_o,
    output csr_pkg::csr_view_t csr_view_o
);

    import commit_pkg::*;
    import csr_pkg::*;

    logic [31:0] crmd_q, prmd_q, ecfg_q, estat_q, era_q, badv_q, eentry_q;
    logic [31:0] crmd_d, prmd_d, ecfg_d, estat_d, era_d, badv_d, eentry_d;

    logic [31:0] old_val;
    logic [31:0] wmask;
    logic [31:0] eff_mask;
    logic [31:0] new_val;
    logic        csr_wr;

    // ----------------------------------------
    // read mux and write mask by number
    always_comb begin
        old_val = '0;
        wmask   = '0;
        case (csr_req_i.num)
            CSR_CRMD: begin
                old_val = crmd_q;
                wmask   = CRMD_WMASK;
            end
            CSR_PRMD: begin
                old_val = prmd_q;
                wmask   = PRMD_WMASK;
            end
            CSR_ECFG: begin
                old_val = ecfg_q;
                wmask   = ECFG_WMASK;
            end
            CSR_ESTAT: begin
                old_val = estat_q;
                wmask   = ESTAT_WMASK;
            end
            CSR_ERA: begin
                old_val = era_q;
                wmask   = ERA_WMASK;
            end
            CSR_BADV: begin
                old_val = badv_q;
                wmask   = BADV_WMASK;
            end
            CSR_EENTRY: begin
                old_val = eentry_q;
                wmask   = EENTRY_WMASK;
            end
            default: begin
                old_val = '0;
            end
        endcase
    end

    assign csr_wr   = csr_req_i.valid &
                      ((csr_req_i.op == CSR_OP_WRITE) | (csr_req_i.op == CSR_OP_XCHG));
    // exchange only touches bits named by the request mask
    assign eff_mask = (csr_req_i.op == CSR_OP_XCHG) ? (wmask & csr_req_i.mask) : wmask;
    assign new_val  = (old_val & ~eff_mask) | (csr_req_i.wdata & eff_mask);

    // ----------------------------------------
    // next state
    always_comb begin
        crmd_d   = crmd_q;
        prmd_d   = prmd_q;
        ecfg_d   = ecfg_q;
        estat_d  = estat_q;
        era_d    = era_q;
        badv_d   = badv_q;
        eentry_d = eentry_q;

        if (csr_wr) begin
            case (csr_req_i.num)
                CSR_CRMD:   crmd_d   = new_val;
                CSR_PRMD:   prmd_d   = new_val;
                CSR_ECFG:   ecfg_d   = new_val;
                CSR_ESTAT:  estat_d  = new_val;
                CSR_ERA:    era_d    = new_val;
                CSR_BADV:   badv_d   = new_val;
                CSR_EENTRY: eentry_d = new_val;
                default:    crmd_d   = crmd_q;
            endcase
        end

        // exception entry saves mode and drops to kernel
        if (exc_req_i.valid) begin
            prmd_d[PRMD_PPLV_HI:PRMD_PPLV_LO]     = crmd_q[CRMD_PLV_HI:CRMD_PLV_LO];
            prmd_d[PRMD_PIE]                      = crmd_q[CRMD_IE];
            crmd_d[CRMD_PLV_HI:CRMD_PLV_LO]       = 2'd0;
            crmd_d[CRMD_IE]                       = 1'b0;
            era_d                                 = exc_req_i.pc;
            estat_d[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = exc_req_i.ecode;
            if (exc_req_i.badv_valid) begin
                badv_d = exc_req_i.badv;
            end
        end

        // hardware lines sampled every edge
        estat_d[ESTAT_HWI_HI:ESTAT_HWI_LO] = hw_int_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_q   <= CRMD_RESET;
            prmd_q   <= '0;
            ecfg_q   <= '0;
            estat_q  <= '0;
            era_q    <= '0;
            badv_q   <= '0;
            eentry_q <= '0;
        end else begin
            crmd_q   <= crmd_d;
            prmd_q   <= prmd_d;
            ecfg_q   <= ecfg_d;
            estat_q  <= estat_d;
            era_q    <= era_d;
            badv_q   <= badv_d;
            eentry_q <= eentry_d;
        end
    end

    // ----------------------------------------
    // outputs
    assign csr_rdata_o = old_val;
    assign eentry_o    = eentry_q;

    assign csr_view_o.plv         = crmd_q[CRMD_PLV_HI:CRMD_PLV_LO];
    assign csr_view_o.ie          = crmd_q[CRMD_IE];
    assign csr_view_o.int_pending = crmd_q[CRMD_IE] &
                                    (|(estat_q[ESTAT_IS_HI:ESTAT_IS_LO] &
                                       ecfg_q[ECFG_LIE_HI:ECFG_LIE_LO]));

    a_exc_enters_kernel: assert property (
        @(posedge clk) disable iff (!rst_n)
        exc_req_i.valid |=> (crmd_q[CRMD_PLV_HI:CRMD_PLV_LO] == 2'd0)
    ) else $error("CRMD.PLV not cleared after exception entry");

endmodule

`default_nettype wire

//--- logic/commit_select.sv
`timescale 1ns/1ps
`default_nettype none

module commit_select (
    input  logic [commit_pkg::COMMIT_WIDTH-1:0]                        rob_valid_i,
    input  commit_pkg::rob_entry_t [commit_pkg::COMMIT_WIDTH-1:0]      rob_entry_i,
    input  commit_pkg::slot_result_t [commit_pkg::COMMIT_WIDTH-1:0]    result_i,
    input  logic [31:0]                                                csr_rdata_i,
    input  logic [31:0]                                                eentry_i,
    output logic [commit_pkg::COMMIT_WIDTH-1:0]                        commit_request_o,
    output logic [commit_pkg::COMMIT_WIDTH-1:0]                        arf_we_o,
    output logic [commit_pkg::COMMIT_WIDTH-1:0][commit_pkg::AREG_W-1:0] arf_areg_o,
    output logic [commit_pkg::COMMIT_WIDTH-1:0][31:0]                  arf_data_o,
    output logic                                                       flush_o,
    output logic [31:0]                                                flush_pc_o,
    output csr_pkg::csr_req_t                                          csr_req_o,
    output csr_pkg::exc_req_t                                          exc_req_o
);

    import commit_pkg::*;

    logic head_csr;
    logic head_csr_wr;

    // ----------------------------------------
    // dual commit rule
    always_comb begin
        commit_request_o[0] = rob_valid_i[0];
        commit_request_o[1] = rob_valid_i[0] & rob_valid_i[1] &
                              ~result_i[0].needs_solo & ~result_i[1].needs_solo;
    end

    assign head_csr    = rob_entry_i[0].csr_op != CSR_OP_NONE;
    assign head_csr_wr = (rob_entry_i[0].csr_op == CSR_OP_WRITE) |
                         (rob_entry_i[0].csr_op == CSR_OP_XCHG);

    // register file write ports
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            arf_we_o[i]   = commit_request_o[i] & rob_entry_i[i].w_reg & ~result_i[i].exc;
            arf_areg_o[i] = rob_entry_i[i].w_areg;
            arf_data_o[i] = rob_entry_i[i].w_data;
        end
        // CSR ops return the old register value
        if (head_csr) begin
            arf_data_o[0] = csr_rdata_i;
        end
    end

    // ----------------------------------------
    // requests to the CSR file
    always_comb begin
        csr_req_o.valid = commit_request_o[0] & head_csr & ~result_i[0].exc;
        csr_req_o.op    = rob_entry_i[0].csr_op;
        csr_req_o.num   = rob_entry_i[0].csr_num;
        csr_req_o.wdata = rob_entry_i[0].csr_wdata;
        csr_req_o.mask  = rob_entry_i[0].csr_mask;

        exc_req_o.valid      = commit_request_o[0] & result_i[0].exc;
        exc_req_o.ecode      = result_i[0].ecode;
        exc_req_o.pc         = rob_entry_i[0].pc;
        exc_req_o.badv_valid = result_i[0].badv_valid;
        exc_req_o.badv       = result_i[0].badv;
    end

    // flush on trap or CSR update
    always_comb begin
        flush_o    = 1'b0;
        flush_pc_o = '0;
        if (exc_req_o.valid) begin
            flush_o    = 1'b1;
            flush_pc_o = eentry_i;
        end else if (csr_req_o.valid && head_csr_wr) begin
            flush_o    = 1'b1;
            flush_pc_o = rob_entry_i[0].pc + 32'd4;
        end
    end

    always_comb begin
        a_slot1_needs_slot0: assert final (!commit_request_o[1] || commit_request_o[0])
            else $error("slot 1 retired without slot 0");
        a_csr_exc_exclusive: assert final (!(csr_req_o.valid && exc_req_o.valid))
            else $error("CSR request and exception request in the same cycle");
    end

endmodule

`default_nettype wire

//--- logic/commit_slot_check.sv
`timescale 1ns/1ps
`default_nettype none

module commit_slot_check (
    input  commit_pkg::rob_entry_t   rob_entry_i,
    input  csr_pkg::csr_view_t       csr_view_i,
    input  logic                     slot_valid_i,
    output commit_pkg::slot_result_t result_o
);

    import commit_pkg::*;
    import csr_pkg::*;

    // ----------------------------------------
    // exception sources in priority order
    logic       int_exc;
    logic       fetch_exc;
    logic       sys_exc;
    logic       brk_exc;
    logic       ine_exc;
    logic       ipe_exc;
    logic       exe_exc;
    logic [6:0] exc_vec;

    assign int_exc   = slot_valid_i & csr_view_i.int_pending;
    assign fetch_exc = slot_valid_i & rob_entry_i.fetch_exc;
    assign sys_exc   = slot_valid_i & rob_entry_i.syscall;
    assign brk_exc   = slot_valid_i & rob_entry_i.brk;
    assign ine_exc   = slot_valid_i & rob_entry_i.decode_err;
    // privileged op only faults in user mode
    assign ipe_exc   = slot_valid_i & rob_entry_i.priv & (csr_view_i.plv == 2'd3);
    assign exe_exc   = slot_valid_i & rob_entry_i.exec_exc;

    assign exc_vec = {int_exc, fetch_exc, sys_exc, brk_exc, ine_exc, ipe_exc, exe_exc};

    // ----------------------------------------
    // fixed priority arbitration
    always_comb begin
        result_o.exc        = |exc_vec;
        result_o.ecode      = '0;
        result_o.badv_valid = 1'b0;
        result_o.badv       = '0;

        priority casez (exc_vec)
            7'b1??????: result_o.ecode = ECODE_INT;
            7'b01?????: begin
                // fetch fault keeps its own code and address
                result_o.ecode      = rob_entry_i.exc_code;
                result_o.badv_valid = 1'b1;
                result_o.badv       = rob_entry_i.va;
            end
            7'b001????: result_o.ecode = ECODE_SYS;
            7'b0001???: result_o.ecode = ECODE_BRK;
            7'b00001??: result_o.ecode = ECODE_INE;
            7'b000001?: result_o.ecode = ECODE_IPE;
            7'b0000001: begin
                result_o.ecode      = rob_entry_i.exc_code;
                result_o.badv_valid = 1'b1;
                result_o.badv       = rob_entry_i.va;
            end
            default: begin
                result_o.ecode = '0;
            end
        endcase

        // anything that touches CSRs or traps goes alone
        result_o.needs_solo = slot_valid_i &
                              (rob_entry_i.solo |
                               (rob_entry_i.csr_op != CSR_OP_NONE) |
                               result_o.exc);
    end

    always_comb begin
        a_no_exc_when_idle: assert final (slot_valid_i || !result_o.exc)
            else $error("exception flagged on an empty slot");
    end

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // ----------------------------------------
    // CSR numbers
    localparam logic [13:0] CSR_CRMD   = 14'h0;
    localparam logic [13:0] CSR_PRMD   = 14'h1;
    localparam logic [13:0] CSR_ECFG   = 14'h4;
    localparam logic [13:0] CSR_ESTAT  = 14'h5;
    localparam logic [13:0] CSR_ERA    = 14'h6;
    localparam logic [13:0] CSR_BADV   = 14'h7;
    localparam logic [13:0] CSR_EENTRY = 14'hC;

    // ----------------------------------------
    // field positions
    localparam int CRMD_PLV_HI    = 1;
    localparam int CRMD_PLV_LO    = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int PRMD_PPLV_HI   = 1;
    localparam int PRMD_PPLV_LO   = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_IS_HI    = 12;
    localparam int ESTAT_IS_LO    = 0;
    // hardware interrupt lines inside IS
    localparam int ESTAT_HWI_HI   = 9;
    localparam int ESTAT_HWI_LO   = 2;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ECFG_LIE_HI    = 12;
    localparam int ECFG_LIE_LO    = 0;

    // exception codes
    localparam logic [5:0] ECODE_INT = 6'h0;
    localparam logic [5:0] ECODE_SYS = 6'hB;
    localparam logic [5:0] ECODE_BRK = 6'hC;
    localparam logic [5:0] ECODE_INE = 6'hD;
    localparam logic [5:0] ECODE_IPE = 6'hE;

    // writable bits per register
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_01FF;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ECFG_WMASK   = 32'h0000_1FFF;
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003;
    localparam logic [31:0] ERA_WMASK    = 32'hFFFF_FFFF;
    localparam logic [31:0] BADV_WMASK   = 32'hFFFF_FFFF;
    localparam logic [31:0] EENTRY_WMASK = 32'hFFFF_FFC0;

    // direct address mode out of reset
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    // ----------------------------------------
    // state the slot checkers look at
    typedef struct packed {
        logic [1:0] plv;
        logic       ie;
        logic       int_pending;
    } csr_view_t;

    // CSR instruction from slot 0
    typedef struct packed {
        logic                valid;
        commit_pkg::csr_op_e op;
        logic [13:0]         num;
        logic [31:0]         wdata;
        logic [31:0]         mask;
    } csr_req_t;

    // exception entry from slot 0
    typedef struct packed {
        logic        valid;
        logic [5:0]  ecode;
        logic [31:0] pc;
        logic        badv_valid;
        logic [31:0] badv;
    } exc_req_t;

endpackage

`default_nettype wire

//--- logic/commit_pkg.sv
`default_nettype none

package commit_pkg;

    // retire slots per cycle
    localparam int COMMIT_WIDTH = 2;
    // architectural register index width
    localparam int AREG_W       = 5;

    // CSR operation carried by a retiring entry
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_READ  = 2'd1,
        CSR_OP_WRITE = 2'd2,
        CSR_OP_XCHG  = 2'd3
    } csr_op_e;

    // ----------------------------------------
    // head entry of the reorder buffer
    typedef struct packed {
        logic [31:0]       pc;
        logic              solo;
        logic              w_reg;
        logic [AREG_W-1:0] w_areg;
        logic [31:0]       w_data;
        csr_op_e           csr_op;
        logic [13:0]       csr_num;
        logic [31:0]       csr_wdata;
        logic [31:0]       csr_mask;
        logic              fetch_exc;
        logic              syscall;
        logic              brk;
        logic              decode_err;
        logic              priv;
        logic              exec_exc;
        logic [5:0]        exc_code;
        logic [31:0]       va;
    } rob_entry_t;

    // classifier output for one slot
    typedef struct packed {
        logic        exc;
        logic [5:0]  ecode;
        logic        badv_valid;
        logic [31:0] badv;
        logic        needs_solo;
    } slot_result_t;

endpackage

`default_nettype wire
